/* hdl/cart_pkg.sv */
package cart_pkg;

  ////////////////////////////////////////////////////////////
  // bus and memory widths
  ////////////////////////////////////////////////////////////
  localparam int SNES_ADDR_W = 24;
  localparam int ROM_ADDR_W  = 23;
  localparam int BYTE_W      = 8;
  localparam int WORD_W      = 16;

  ////////////////////////////////////////////////////////////
  // console bus sampling
  ////////////////////////////////////////////////////////////
  localparam int SYNC_DEPTH = 8;
  localparam int ADDR_DELAY = 7;

  // edge windows, six filtered samples oldest first
  localparam int             EDGE_WIN     = 6;
  localparam [EDGE_WIN-1:0]  RISE_PATTERN = 6'b000011;
  localparam [EDGE_WIN-1:0]  FALL_PATTERN = 6'b111000;

  ////////////////////////////////////////////////////////////
  // timing
  ////////////////////////////////////////////////////////////
  localparam int ROM_CYCLE_LEN = 7;
  localparam int DELAY_W       = $clog2(ROM_CYCLE_LEN + 1);

  // about 1 ms of CLK2 with the console clock stuck low
  localparam int DEAD_TIMEOUT = 96000;
  localparam int DEAD_CNT_W   = 18;

  ////////////////////////////////////////////////////////////
  // request kinds and sequencer states
  ////////////////////////////////////////////////////////////
  typedef enum logic [1:0] {
    REQ_NONE,
    REQ_MCU_RD,
    REQ_MCU_WR,
    REQ_CTX_WR
  } req_kind_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_MCU_RD_ADDR,
    ST_MCU_RD_END,
    ST_MCU_WR_ADDR,
    ST_MCU_WR_END,
    ST_CTX_WR_ADDR,
    ST_CTX_WR_END
  } seq_state_t;

endpackage

/* hdl/bus_sync.sv */
`timescale 1ns/100ps

module bus_sync (
  input  logic                             CLK2,
  input  logic                             rst_n,
  input  logic [cart_pkg::SNES_ADDR_W-1:0] snes_addr_in,
  input  logic                             snes_read_in,
  input  logic                             snes_romsel_in,
  input  logic                             snes_cpu_clk_in,
  output logic [cart_pkg::SNES_ADDR_W-1:0] snes_addr,
  output logic                             snes_read,
  output logic                             snes_romsel,
  output logic                             snes_cpu_clk,
  output logic                             cpu_clk_raw,
  output logic                             cycle_start,
  output logic                             cycle_end
);
  import cart_pkg::*;

  logic [SYNC_DEPTH-1:0]  clk_sr;
  logic [SYNC_DEPTH-1:0]  read_sr;
  logic [SYNC_DEPTH-1:0]  romsel_sr;
  logic [SNES_ADDR_W-1:0] addr_pipe [ADDR_DELAY];

  ////////////////////////////////////////////////////////////
  // control sampling, tap 0 is the newest sample
  ////////////////////////////////////////////////////////////
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      clk_sr    <= '0;
      read_sr   <= '1;
      romsel_sr <= '1;
    end else begin
      clk_sr    <= {clk_sr[SYNC_DEPTH-2:0], snes_cpu_clk_in};
      read_sr   <= {read_sr[SYNC_DEPTH-2:0], snes_read_in};
      romsel_sr <= {romsel_sr[SYNC_DEPTH-2:0], snes_romsel_in};
    end
  end

  // address pipeline, long enough for the romsel filter to settle
  always_ff @(posedge CLK2) begin
    addr_pipe[0] <= snes_addr_in;
    for (int i = 1; i < ADDR_DELAY; i++) begin
      addr_pipe[i] <= addr_pipe[i-1];
    end
  end

  ////////////////////////////////////////////////////////////
  // glitch filters
  ////////////////////////////////////////////////////////////
  // a level must be seen on two adjacent taps
  assign snes_cpu_clk = clk_sr[2] & clk_sr[1];
  assign snes_read    = read_sr[2] & read_sr[1];
  assign snes_romsel  = romsel_sr[5] & romsel_sr[4];
  assign snes_addr    = addr_pipe[ADDR_DELAY-1] & addr_pipe[ADDR_DELAY-2];
  assign cpu_clk_raw  = clk_sr[1];

  // single-sample spikes vanish in the AND/OR of shifted windows
  assign cycle_start = (clk_sr[7:2] & clk_sr[6:1]) == RISE_PATTERN;
  assign cycle_end   = (clk_sr[7:2] | clk_sr[6:1]) == FALL_PATTERN;

  a_edges_exclusive: assert property (
    @(posedge CLK2) disable iff (!rst_n) !(cycle_start && cycle_end)
  );

endmodule

/* hdl/liveness_monitor.sv */
`timescale 1ns/100ps

module liveness_monitor (
  input  logic CLK2,
  input  logic rst_n,
  input  logic cpu_clk_raw,
  output logic snes_dead,
  output logic snes_reset
);
  import cart_pkg::*;

  logic [DEAD_CNT_W-1:0] dead_cnt;

  // time spent with the console clock low, saturates
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      dead_cnt <= '0;
    end else if (cpu_clk_raw) begin
      dead_cnt <= '0;
    end else if (dead_cnt != '1) begin
      dead_cnt <= dead_cnt + 1'b1;
    end
  end

  // console counts as dead until its clock is seen again
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      snes_dead  <= 1'b1;
      snes_reset <= 1'b0;
    end else begin
      snes_reset <= 1'b0;
      if (cpu_clk_raw) begin
        snes_dead  <= 1'b0;
        snes_reset <= snes_dead;
      end else if (dead_cnt > DEAD_TIMEOUT) begin
        snes_dead <= 1'b1;
      end
    end
  end

endmodule

/* hdl/rom_request.sv */
`timescale 1ns/100ps

module rom_request (
  input  logic                             CLK2,
  input  logic                             rst_n,
  input  logic                             mcu_rrq,
  input  logic                             mcu_wrq,
  input  logic [cart_pkg::SNES_ADDR_W-1:0] mcu_addr,
  input  logic [cart_pkg::BYTE_W-1:0]      mcu_wdata,
  input  logic                             ctx_wrq,
  input  logic [cart_pkg::SNES_ADDR_W-1:0] ctx_addr,
  input  logic [cart_pkg::WORD_W-1:0]      ctx_data,
  input  logic                             ctx_word,
  input  cart_pkg::seq_state_t             seq_state,
  output cart_pkg::req_kind_t              pending_kind,
  output logic                             mcu_rdy,
  output logic                             ctx_rdy,
  output logic [cart_pkg::SNES_ADDR_W-1:0] req_addr,
  output logic [cart_pkg::WORD_W-1:0]      req_wdata,
  output logic                             req_word
);
  import cart_pkg::*;

  logic                   mcu_rd_pend;
  logic                   mcu_wr_pend;
  logic                   ctx_pend;
  logic [SNES_ADDR_W-1:0] mcu_addr_q;
  logic [BYTE_W-1:0]      mcu_wdata_q;
  logic [SNES_ADDR_W-1:0] ctx_addr_q;
  logic [WORD_W-1:0]      ctx_data_q;
  logic                   ctx_word_q;
  logic                   mcu_done;
  logic                   ctx_take;
  logic                   ctx_sel;

  assign mcu_done = (seq_state == ST_MCU_RD_END) || (seq_state == ST_MCU_WR_END);
  // ctx_wrq is a level, only the first cycle of it counts
  assign ctx_take = ctx_wrq && !ctx_pend;
  assign ctx_sel  = seq_state == ST_CTX_WR_ADDR;

  ////////////////////////////////////////////////////////////
  // pending flags and ready handshakes
  ////////////////////////////////////////////////////////////
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      mcu_rd_pend <= 1'b0;
      mcu_wr_pend <= 1'b0;
      mcu_rdy     <= 1'b1;
    end else if (mcu_rrq) begin
      mcu_rd_pend <= 1'b1;
      mcu_rdy     <= 1'b0;
    end else if (mcu_wrq) begin
      mcu_wr_pend <= 1'b1;
      mcu_rdy     <= 1'b0;
    end else if (mcu_done) begin
      mcu_rd_pend <= 1'b0;
      mcu_wr_pend <= 1'b0;
      mcu_rdy     <= 1'b1;
    end
  end

  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      ctx_pend <= 1'b0;
      ctx_rdy  <= 1'b1;
    end else if (ctx_take) begin
      ctx_pend <= 1'b1;
      ctx_rdy  <= 1'b0;
    end else if (seq_state == ST_CTX_WR_END) begin
      ctx_pend <= 1'b0;
      ctx_rdy  <= 1'b1;
    end
  end

  // request payload
  always_ff @(posedge CLK2) begin
    if (mcu_rrq || mcu_wrq) begin
      mcu_addr_q <= mcu_addr;
    end
    if (mcu_wrq) begin
      mcu_wdata_q <= mcu_wdata;
    end
    if (ctx_take) begin
      ctx_addr_q <= ctx_addr;
      ctx_data_q <= ctx_data;
      ctx_word_q <= ctx_word;
    end
  end

  ////////////////////////////////////////////////////////////
  // winner and payload of the running access
  ////////////////////////////////////////////////////////////
  always_comb begin
    if (ctx_pend) begin
      pending_kind = REQ_CTX_WR;
    end else if (mcu_rd_pend) begin
      pending_kind = REQ_MCU_RD;
    end else if (mcu_wr_pend) begin
      pending_kind = REQ_MCU_WR;
    end else begin
      pending_kind = REQ_NONE;
    end
  end

  // mcu byte goes out on both halves, the port picks the lane
  assign req_addr  = ctx_sel ? ctx_addr_q : mcu_addr_q;
  assign req_wdata = ctx_sel ? ctx_data_q : {mcu_wdata_q, mcu_wdata_q};
  assign req_word  = ctx_sel && ctx_word_q;

  a_mcu_req_when_ready: assert property (
    @(posedge CLK2) disable iff (!rst_n) (mcu_rrq || mcu_wrq) |-> mcu_rdy
  );

endmodule

/* hdl/rom_sequencer.sv */
`timescale 1ns/100ps

module rom_sequencer (
  input  logic                        CLK2,
  input  logic                        rst_n,
  input  cart_pkg::req_kind_t         pending_kind,
  input  logic                        snes_dead,
  input  logic                        cpu_clk_raw,
  input  logic                        cycle_start,
  input  logic                        cycle_end,
  input  logic                        snes_romsel,
  input  logic                        req_addr0,
  input  logic [cart_pkg::WORD_W-1:0] rom_rdata,
  output cart_pkg::seq_state_t        seq_state,
  output logic [cart_pkg::BYTE_W-1:0] mcu_rdata
);
  import cart_pkg::*;

  logic [DELAY_W-1:0] delay_cnt;
  logic               free_strobe;
  logic               free_slot;
  logic               revive;
  logic               in_addr;

  // console cycle that misses the ROM leaves the PSRAM free
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      free_strobe <= 1'b0;
    end else begin
      free_strobe <= cycle_start && snes_romsel;
    end
  end

  assign free_slot = cycle_end || free_strobe;
  assign revive    = snes_dead && cpu_clk_raw;
  assign in_addr   = (seq_state == ST_MCU_RD_ADDR) || (seq_state == ST_MCU_WR_ADDR) ||
                     (seq_state == ST_CTX_WR_ADDR);

  ////////////////////////////////////////////////////////////
  // arbitration FSM
  ////////////////////////////////////////////////////////////
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      seq_state <= ST_IDLE;
      delay_cnt <= '0;
    end else if (revive) begin
      // console back, drop the access; its request stays pending
      seq_state <= ST_IDLE;
    end else begin
      case (seq_state)
        ST_IDLE: begin
          if ((free_slot || snes_dead) && pending_kind != REQ_NONE) begin
            delay_cnt <= DELAY_W'(ROM_CYCLE_LEN);
            case (pending_kind)
              REQ_CTX_WR: seq_state <= ST_CTX_WR_ADDR;
              REQ_MCU_RD: seq_state <= ST_MCU_RD_ADDR;
              default:    seq_state <= ST_MCU_WR_ADDR;
            endcase
          end
        end
        ST_MCU_RD_ADDR: begin
          delay_cnt <= delay_cnt - 1'b1;
          if (delay_cnt == '0) seq_state <= ST_MCU_RD_END;
        end
        ST_MCU_WR_ADDR: begin
          delay_cnt <= delay_cnt - 1'b1;
          if (delay_cnt == '0) seq_state <= ST_MCU_WR_END;
        end
        ST_CTX_WR_ADDR: begin
          delay_cnt <= delay_cnt - 1'b1;
          if (delay_cnt == '0) seq_state <= ST_CTX_WR_END;
        end
        default: begin
          seq_state <= ST_IDLE;
        end
      endcase
    end
  end

  // read data keeps following the bus, last sample wins
  always_ff @(posedge CLK2) begin
    if (seq_state == ST_MCU_RD_ADDR) begin
      mcu_rdata <= req_addr0 ? rom_rdata[BYTE_W-1:0] : rom_rdata[WORD_W-1:BYTE_W];
    end
  end

  a_hold_until_expired: assert property (
    @(posedge CLK2) disable iff (!rst_n)
    (in_addr && delay_cnt != '0 && !revive) |=> seq_state == $past(seq_state)
  );

endmodule

/* hdl/rom_port.sv */
`timescale 1ns/100ps

module rom_port (
  input  cart_pkg::seq_state_t             seq_state,
  input  logic [cart_pkg::SNES_ADDR_W-1:0] req_addr,
  input  logic [cart_pkg::WORD_W-1:0]      req_wdata,
  input  logic                             req_word,
  input  logic [cart_pkg::SNES_ADDR_W-1:0] mcu_rom_mask,
  input  logic [cart_pkg::SNES_ADDR_W-1:0] snes_addr,
  input  logic                             snes_read,
  input  logic                             snes_romsel,
  input  logic [cart_pkg::WORD_W-1:0]      rom_rdata,
  output logic [cart_pkg::ROM_ADDR_W-1:0]  rom_addr,
  output logic [cart_pkg::WORD_W-1:0]      rom_wdata,
  output logic                             rom_data_oe,
  output logic                             rom_we,
  output logic                             rom_bhe,
  output logic                             rom_ble,
  output logic [cart_pkg::BYTE_W-1:0]      snes_rdata,
  output logic                             snes_data_oe
);
  import cart_pkg::*;

  logic                   acc_hit;
  logic                   wr_hit;
  logic [SNES_ADDR_W-1:0] mapped_addr;
  logic [SNES_ADDR_W-1:0] sel_addr;
  logic                   addr0;

  ////////////////////////////////////////////////////////////
  // address steering
  ////////////////////////////////////////////////////////////
  assign wr_hit  = (seq_state == ST_MCU_WR_ADDR) || (seq_state == ST_CTX_WR_ADDR);
  assign acc_hit = wr_hit || (seq_state == ST_MCU_RD_ADDR);

  // the mapper is only the ROM mask here
  assign mapped_addr = snes_addr & mcu_rom_mask;

  // req_addr already carries the context access over the mcu one
  assign sel_addr = acc_hit ? req_addr : mapped_addr;
  assign rom_addr = sel_addr[SNES_ADDR_W-1:1];
  // 1 selects the low lane [7:0]
  assign addr0    = sel_addr[0];

  ////////////////////////////////////////////////////////////
  // data lanes and strobes
  ////////////////////////////////////////////////////////////
  // data[15:8] lands on the low lane, data[7:0] on the high lane
  assign rom_wdata   = {req_wdata[BYTE_W-1:0], req_wdata[WORD_W-1:BYTE_W]};
  assign rom_data_oe = wr_hit;
  assign rom_we      = !wr_hit;

  // byte enables are active low, a word write opens both
  assign rom_bhe = addr0 && !req_word;
  assign rom_ble = !addr0 && !req_word;

  assign snes_rdata   = addr0 ? rom_rdata[BYTE_W-1:0] : rom_rdata[WORD_W-1:BYTE_W];
  assign snes_data_oe = !snes_read && !snes_romsel;

endmodule

/* hdl/cart_mem_core.sv */
`timescale 1ns/100ps

module cart_mem_core (
  input  logic                             CLK2,
  input  logic                             rst_n,
  // console bus, raw
  input  logic [cart_pkg::SNES_ADDR_W-1:0] snes_addr_in,
  input  logic                             snes_read_in,
  input  logic                             snes_romsel_in,
  input  logic                             snes_cpu_clk_in,
  // MCU
  input  logic                             mcu_rrq,
  input  logic                             mcu_wrq,
  input  logic [cart_pkg::SNES_ADDR_W-1:0] mcu_addr,
  input  logic [cart_pkg::BYTE_W-1:0]      mcu_wdata,
  input  logic [cart_pkg::SNES_ADDR_W-1:0] mcu_rom_mask,
  output logic                             mcu_rdy,
  output logic [cart_pkg::BYTE_W-1:0]      mcu_rdata,
  // context engine
  input  logic                             ctx_wrq,
  input  logic [cart_pkg::SNES_ADDR_W-1:0] ctx_addr,
  input  logic [cart_pkg::WORD_W-1:0]      ctx_data,
  input  logic                             ctx_word,
  output logic                             ctx_rdy,
  // PSRAM
  output logic [cart_pkg::ROM_ADDR_W-1:0]  rom_addr,
  output logic [cart_pkg::WORD_W-1:0]      rom_wdata,
  output logic                             rom_data_oe,
  input  logic [cart_pkg::WORD_W-1:0]      rom_rdata,
  output logic                             rom_we,
  output logic                             rom_bhe,
  output logic                             rom_ble,
  // console data and reset
  output logic [cart_pkg::BYTE_W-1:0]      snes_rdata,
  output logic                             snes_data_oe,
  output logic                             snes_reset
);
  import cart_pkg::*;

  logic [SNES_ADDR_W-1:0] snes_addr;
  logic                   snes_read;
  logic                   snes_romsel;
  logic                   cpu_clk_raw;
  logic                   cycle_start;
  logic                   cycle_end;
  logic                   snes_dead;
  req_kind_t              pending_kind;
  seq_state_t             seq_state;
  logic [SNES_ADDR_W-1:0] req_addr;
  logic [WORD_W-1:0]      req_wdata;
  logic                   req_word;

  bus_sync u_bus_sync (
    .CLK2            (CLK2),
    .rst_n           (rst_n),
    .snes_addr_in    (snes_addr_in),
    .snes_read_in    (snes_read_in),
    .snes_romsel_in  (snes_romsel_in),
    .snes_cpu_clk_in (snes_cpu_clk_in),
    .snes_addr       (snes_addr),
    .snes_read       (snes_read),
    .snes_romsel     (snes_romsel),
    .snes_cpu_clk    (),
    .cpu_clk_raw     (cpu_clk_raw),
    .cycle_start     (cycle_start),
    .cycle_end       (cycle_end)
  );

  liveness_monitor u_liveness (
    .CLK2        (CLK2),
    .rst_n       (rst_n),
    .cpu_clk_raw (cpu_clk_raw),
    .snes_dead   (snes_dead),
    .snes_reset  (snes_reset)
  );

  rom_request u_request (
    .CLK2         (CLK2),
    .rst_n        (rst_n),
    .mcu_rrq      (mcu_rrq),
    .mcu_wrq      (mcu_wrq),
    .mcu_addr     (mcu_addr),
    .mcu_wdata    (mcu_wdata),
    .ctx_wrq      (ctx_wrq),
    .ctx_addr     (ctx_addr),
    .ctx_data     (ctx_data),
    .ctx_word     (ctx_word),
    .seq_state    (seq_state),
    .pending_kind (pending_kind),
    .mcu_rdy      (mcu_rdy),
    .ctx_rdy      (ctx_rdy),
    .req_addr     (req_addr),
    .req_wdata    (req_wdata),
    .req_word     (req_word)
  );

  rom_sequencer u_sequencer (
    .CLK2         (CLK2),
    .rst_n        (rst_n),
    .pending_kind (pending_kind),
    .snes_dead    (snes_dead),
    .cpu_clk_raw  (cpu_clk_raw),
    .cycle_start  (cycle_start),
    .cycle_end    (cycle_end),
    .snes_romsel  (snes_romsel),
    .req_addr0    (req_addr[0]),
    .rom_rdata    (rom_rdata),
    .seq_state    (seq_state),
    .mcu_rdata    (mcu_rdata)
  );

  rom_port u_port (
    .seq_state    (seq_state),
    .req_addr     (req_addr),
    .req_wdata    (req_wdata),
    .req_word     (req_word),
    .mcu_rom_mask (mcu_rom_mask),
    .snes_addr    (snes_addr),
    .snes_read    (snes_read),
    .snes_romsel  (snes_romsel),
    .rom_rdata    (rom_rdata),
    .rom_addr     (rom_addr),
    .rom_wdata    (rom_wdata),
    .rom_data_oe  (rom_data_oe),
    .rom_we       (rom_we),
    .rom_bhe      (rom_bhe),
    .rom_ble      (rom_ble),
    .snes_rdata   (snes_rdata),
    .snes_data_oe (snes_data_oe)
  );

endmodule

/* verification/clk_gen.sv */
`timescale 1ns/100ps

module clk_gen (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_NS      = 2;
  localparam int RESET_CYCLES = 4;

  initial begin
    clk = 1'b0;
    forever #(HALF_NS) clk = ~clk;
  end

  // reset released on a falling edge, away from the sampling edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

/* verification/tb_cart_mem_core.sv */
`timescale 1ns/100ps

module tb_cart_mem_core;
  import cart_pkg::*;

  localparam int CLK_PERIOD_NS = 4;
  localparam int WIN_BITS      = 10;
  localparam int WIN_BYTES     = 1 << WIN_BITS;
  localparam int NUM_WR        = 40;
  localparam int NUM_RD        = 40;
  localparam int NUM_CTX       = 24;
  localparam int NUM_BUS       = 60;
  localparam int OP_LIMIT      = 400;
  localparam int SETTLE        = 8;
  localparam int STOP_CYCLES   = DEAD_TIMEOUT + 64;
  localparam int TEST_CYCLES   = (NUM_WR + NUM_RD + 2 * NUM_CTX + 4) * OP_LIMIT
                                 + NUM_BUS * 40 + STOP_CYCLES + 1000;
  localparam int WATCHDOG_NS   = (TEST_CYCLES + 2 * DEAD_TIMEOUT) * CLK_PERIOD_NS;

  logic                   CLK2;
  logic                   rst_n;
  logic [SNES_ADDR_W-1:0] snes_addr_in;
  logic                   snes_read_in;
  logic                   snes_romsel_in;
  logic                   snes_cpu_clk_in;
  logic                   mcu_rrq;
  logic                   mcu_wrq;
  logic [SNES_ADDR_W-1:0] mcu_addr;
  logic [BYTE_W-1:0]      mcu_wdata;
  logic [SNES_ADDR_W-1:0] mcu_rom_mask;
  logic                   mcu_rdy;
  logic [BYTE_W-1:0]      mcu_rdata;
  logic                   ctx_wrq;
  logic [SNES_ADDR_W-1:0] ctx_addr;
  logic [WORD_W-1:0]      ctx_data;
  logic                   ctx_word;
  logic                   ctx_rdy;
  logic [ROM_ADDR_W-1:0]  rom_addr;
  logic [WORD_W-1:0]      rom_wdata;
  logic                   rom_data_oe;
  logic [WORD_W-1:0]      rom_rdata;
  logic                   rom_we;
  logic                   rom_bhe;
  logic                   rom_ble;
  logic [BYTE_W-1:0]      snes_rdata;
  logic                   snes_data_oe;
  logic                   snes_reset;

  logic [WORD_W-1:0] psram [WIN_BYTES/2];
  logic [BYTE_W-1:0] ref_mem [WIN_BYTES];

  integer seed        = 32'h3e11_ed19;
  int     err_count   = 0;
  int     check_count = 0;
  int     reset_count = 0;
  int     bus_checks  = 0;
  int     bus_age     = 0;
  bit     clk_run     = 1'b1;
  bit     check_bus   = 1'b0;

  clk_gen u_clk_gen (
    .clk   (CLK2),
    .rst_n (rst_n)
  );

  cart_mem_core uut (
    .CLK2            (CLK2),
    .rst_n           (rst_n),
    .snes_addr_in    (snes_addr_in),
    .snes_read_in    (snes_read_in),
    .snes_romsel_in  (snes_romsel_in),
    .snes_cpu_clk_in (snes_cpu_clk_in),
    .mcu_rrq         (mcu_rrq),
    .mcu_wrq         (mcu_wrq),
    .mcu_addr        (mcu_addr),
    .mcu_wdata       (mcu_wdata),
    .mcu_rom_mask    (mcu_rom_mask),
    .mcu_rdy         (mcu_rdy),
    .mcu_rdata       (mcu_rdata),
    .ctx_wrq         (ctx_wrq),
    .ctx_addr        (ctx_addr),
    .ctx_data        (ctx_data),
    .ctx_word        (ctx_word),
    .ctx_rdy         (ctx_rdy),
    .rom_addr        (rom_addr),
    .rom_wdata       (rom_wdata),
    .rom_data_oe     (rom_data_oe),
    .rom_rdata       (rom_rdata),
    .rom_we          (rom_we),
    .rom_bhe         (rom_bhe),
    .rom_ble         (rom_ble),
    .snes_rdata      (snes_rdata),
    .snes_data_oe    (snes_data_oe),
    .snes_reset      (snes_reset)
  );

  ////////////////////////////////////////////////////////////
  // PSRAM model, async read, byte enables active low
  ////////////////////////////////////////////////////////////
  assign rom_rdata = psram[rom_addr[WIN_BITS-2:0]];

  always @(posedge CLK2) begin
    if (!rom_we) begin
      if (!rom_ble) begin
        psram[rom_addr[WIN_BITS-2:0]][BYTE_W-1:0] <= rom_wdata[BYTE_W-1:0];
      end
      if (!rom_bhe) begin
        psram[rom_addr[WIN_BITS-2:0]][WORD_W-1:BYTE_W] <= rom_wdata[WORD_W-1:BYTE_W];
      end
    end
  end

  // data pins belong to the core only while it writes
  always @(negedge CLK2) begin
    if (snes_reset) begin
      reset_count++;
    end
    check_flag("rom_data_oe", rom_data_oe, !rom_we);
  end

  function automatic logic [WORD_W-1:0] fill_word(input int w);
    return WORD_W'((w * 40503) ^ 32'h0000_c3a5);
  endfunction

  // odd byte address is the low lane
  function automatic logic [BYTE_W-1:0] psram_byte(input logic [WIN_BITS-1:0] a);
    logic [WORD_W-1:0] w;
    w = psram[a[WIN_BITS-1:1]];
    return a[0] ? w[BYTE_W-1:0] : w[WORD_W-1:BYTE_W];
  endfunction

  // context write, even byte takes data[7:0] and odd byte data[15:8]
  task automatic ref_ctx_write(input logic [WIN_BITS-1:0] a, input logic [WORD_W-1:0] d,
                               input logic word);
    if (word || !a[0]) begin
      ref_mem[{a[WIN_BITS-1:1], 1'b0}] = d[BYTE_W-1:0];
    end
    if (word || a[0]) begin
      ref_mem[{a[WIN_BITS-1:1], 1'b1}] = d[WORD_W-1:BYTE_W];
    end
  endtask

  task automatic check_byte(input string what, input logic [BYTE_W-1:0] got,
                            input logic [BYTE_W-1:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("MISMATCH at %0t: %s, got %02h, expected %02h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("MISMATCH at %0t: %s, got %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic report_test(input int num, input string name, input int errs_before);
    if (err_count == errs_before) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: %0d errors", num, name, err_count - errs_before);
    end
  endtask

  // returns on a falling edge with the wanted ready flags high, or gives up
  task automatic wait_ready(input bit want_mcu, input bit want_ctx, output bit ok);
    int n;
    n = 0;
    while (!((!want_mcu || mcu_rdy) && (!want_ctx || ctx_rdy)) && n < OP_LIMIT) begin
      @(negedge CLK2);
      n++;
    end
    ok = (!want_mcu || mcu_rdy) && (!want_ctx || ctx_rdy);
    if (!ok) begin
      err_count++;
      $display("timeout at %0t: request not finished after %0d cycles", $time, OP_LIMIT);
    end
  endtask

  task automatic mcu_access(input bit is_write, input logic [WIN_BITS-1:0] a,
                            input logic [BYTE_W-1:0] wd, output bit ok);
    wait_ready(1'b1, 1'b0, ok);
    if (ok) begin
      mcu_addr  = {{(SNES_ADDR_W-WIN_BITS){1'b0}}, a};
      mcu_wdata = wd;
      mcu_wrq   = is_write;
      mcu_rrq   = !is_write;
      @(negedge CLK2);
      mcu_wrq = 1'b0;
      mcu_rrq = 1'b0;
      wait_ready(1'b1, 1'b0, ok);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // console model, new bus cycle on every falling CPU clock
  ////////////////////////////////////////////////////////////
  initial begin : console_model
    int                     half_left;
    logic [31:0]            rnd;
    logic [SNES_ADDR_W-1:0] masked;
    half_left       = 0;
    snes_cpu_clk_in = 1'b0;
    snes_read_in    = 1'b1;
    snes_romsel_in  = 1'b1;
    snes_addr_in    = '0;
    forever begin
      @(negedge CLK2);
      // the filtered bus has caught up with the pins by now
      if (check_bus && bus_age == SETTLE) begin
        masked = snes_addr_in & mcu_rom_mask;
        check_flag("snes_data_oe", snes_data_oe, !snes_read_in && !snes_romsel_in);
        if (!snes_read_in && !snes_romsel_in) begin
          check_byte("snes_rdata", snes_rdata, ref_mem[masked[WIN_BITS-1:0]]);
        end
        bus_checks++;
      end
      bus_age++;
      if (!clk_run) begin
        snes_cpu_clk_in = 1'b0;
        half_left       = 0;
      end else if (half_left == 0) begin
        rnd             = $random(seed);
        half_left       = 2 + int'(rnd[1:0]);
        snes_cpu_clk_in = !snes_cpu_clk_in;
        if (!snes_cpu_clk_in) begin
          snes_addr_in   = rnd[31:8];
          snes_read_in   = rnd[2];
          snes_romsel_in = rnd[3];
          bus_age        = 0;
        end
      end else begin
        half_left--;
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("watchdog: run still going after %0d ns, stopped", WATCHDOG_NS);
    $display("Simulation FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////
  initial begin : main_sequence
    logic [31:0]         rnd;
    logic [WIN_BITS-1:0] addr;
    logic [WIN_BITS-1:0] raddr;
    logic [WIN_BITS-1:0] even;
    logic [WIN_BITS-1:0] odd;
    logic [BYTE_W-1:0]   wd;
    logic [WORD_W-1:0]   fw;
    bit                  ok;
    int                  n;
    int                  errs_before;
    int                  resets_before;
    mcu_rrq      = 1'b0;
    mcu_wrq      = 1'b0;
    mcu_addr     = '0;
    mcu_wdata    = '0;
    // narrower than the model window so a missing mask shows up
    mcu_rom_mask = 24'h0001ff;
    ctx_wrq      = 1'b0;
    ctx_addr     = '0;
    ctx_data     = '0;
    ctx_word     = 1'b0;
    for (int w = 0; w < WIN_BYTES / 2; w++) begin
      fw                 = fill_word(w);
      psram[w]          <= fw;
      ref_mem[2 * w]     = fw[WORD_W-1:BYTE_W];
      ref_mem[2 * w + 1] = fw[BYTE_W-1:0];
    end
    @(posedge rst_n);
    // let the console clock revive the core first
    repeat (60) @(negedge CLK2);

    errs_before = err_count;
    for (int i = 0; i < NUM_WR; i++) begin
      rnd  = $random(seed);
      addr = rnd[WIN_BITS-1:0];
      wd   = rnd[31:24];
      mcu_access(1'b1, addr, wd, ok);
      if (ok) begin
        ref_mem[addr] = wd;
        check_byte("psram byte after mcu write", psram_byte(addr), wd);
      end
    end
    report_test(1, "mcu writes", errs_before);

    errs_before = err_count;
    for (int i = 0; i < NUM_RD; i++) begin
      rnd  = $random(seed);
      addr = rnd[WIN_BITS-1:0];
      mcu_access(1'b0, addr, '0, ok);
      if (ok) begin
        check_byte("mcu_rdata", mcu_rdata, ref_mem[addr]);
      end
    end
    report_test(2, "mcu reads", errs_before);

    errs_before = err_count;
    for (int i = 0; i < NUM_CTX; i++) begin
      rnd   = $random(seed);
      addr  = rnd[WIN_BITS-1:0];
      raddr = {addr[WIN_BITS-1:1], rnd[11]};
      even  = {addr[WIN_BITS-1:1], 1'b0};
      odd   = {addr[WIN_BITS-1:1], 1'b1};
      wait_ready(1'b1, 1'b1, ok);
      if (ok) begin
        ctx_addr = {{(SNES_ADDR_W-WIN_BITS){1'b0}}, addr};
        ctx_data = rnd[31:16];
        ctx_word = rnd[10];
        ctx_wrq  = 1'b1;
        // read of the same word in the same cycle, context goes first
        mcu_addr = {{(SNES_ADDR_W-WIN_BITS){1'b0}}, raddr};
        mcu_rrq  = 1'b1;
        @(negedge CLK2);
        ctx_wrq = 1'b0;
        mcu_rrq = 1'b0;
        ref_ctx_write(addr, rnd[31:16], rnd[10]);
        wait_ready(1'b1, 1'b1, ok);
        if (ok) begin
          check_byte("mcu read behind ctx write", mcu_rdata, ref_mem[raddr]);
          check_byte("even byte after ctx write", psram_byte(even), ref_mem[even]);
          check_byte("odd byte after ctx write", psram_byte(odd), ref_mem[odd]);
        end
      end
    end
    report_test(3, "context writes", errs_before);

    errs_before = err_count;
    @(posedge CLK2);
    check_bus = 1'b1;
    n = 0;
    while (bus_checks < NUM_BUS && n < NUM_BUS * 40) begin
      @(negedge CLK2);
      n++;
    end
    @(posedge CLK2);
    check_bus = 1'b0;
    @(negedge CLK2);
    if (bus_checks < NUM_BUS) begin
      err_count++;
      $display("console bus never held still long enough, %0d samples taken", bus_checks);
    end
    report_test(4, "console reads", errs_before);

    errs_before = err_count;
    @(posedge CLK2);
    clk_run       = 1'b0;
    resets_before = reset_count;
    repeat (STOP_CYCLES) @(negedge CLK2);
    rnd  = $random(seed);
    addr = rnd[WIN_BITS-1:0];
    wd   = rnd[31:24];
    mcu_access(1'b1, addr, wd, ok);
    if (ok) begin
      ref_mem[addr] = wd;
      mcu_access(1'b0, addr, '0, ok);
    end
    if (ok) begin
      check_byte("mcu read while console dead", mcu_rdata, ref_mem[addr]);
    end
    check_flag("no snes_reset while stopped", reset_count == resets_before, 1'b1);
    resets_before = reset_count;
    @(posedge CLK2);
    clk_run = 1'b1;
    repeat (200) @(negedge CLK2);
    check_flag("one snes_reset pulse on revival", reset_count - resets_before == 1, 1'b1);
    report_test(5, "dead console", errs_before);

    $display("checks: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
hdl/cart_pkg.sv
hdl/bus_sync.sv
hdl/liveness_monitor.sv
hdl/rom_request.sv
hdl/rom_sequencer.sv
hdl/rom_port.sv
hdl/cart_mem_core.sv
verification/clk_gen.sv
verification/tb_cart_mem_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -Mdir obj_dir \
  --top-module tb_cart_mem_core -f vlog.f
./obj_dir/Vtb_cart_mem_core | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
  exit 0
fi
echo "run did not pass, see sim.log"
exit 1
